/* mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath
`define MIPS_DATA_W      32

// register file
`define MIPS_REG_AW      5
`define MIPS_REG_NUM     32

// wishbone window, registers sit at 0x80 + 4*n
`define MIPS_WB_AW       8
`define MIPS_WB_REG_SEL  7
`define MIPS_WB_INST_ADR 8'h00

`endif

/* mips_pkg.sv */
`include "mips_cfg.svh"

package mips_pkg;

    typedef logic [`MIPS_DATA_W-1:0] word_t;
    typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;

    // primary opcodes kept in this core
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_PREF    = 6'b110011
    } opcode_e;

    // SPECIAL function field, nop is sll with shamt zero
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_MOVZ = 6'b001010,
        FN_MOVN = 6'b001011,
        FN_SYNC = 6'b001111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } func_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'd0,
        SEL_LOGIC = 3'd1,
        SEL_SHIFT = 3'd2,
        SEL_MOVE  = 3'd3,
        SEL_ARITH = 3'd4
    } alu_sel_e;

    typedef enum logic [7:0] {
        ALU_NOP  = 8'h00,
        ALU_SRL  = 8'h02,
        ALU_SRA  = 8'h03,
        ALU_MOVZ = 8'h0a,
        ALU_MOVN = 8'h0b,
        ALU_ADD  = 8'h20,
        ALU_ADDU = 8'h21,
        ALU_SUB  = 8'h22,
        ALU_SUBU = 8'h23,
        ALU_AND  = 8'h24,
        ALU_OR   = 8'h25,
        ALU_XOR  = 8'h26,
        ALU_NOR  = 8'h27,
        ALU_SLT  = 8'h2a,
        ALU_SLTU = 8'h2b,
        ALU_SLL  = 8'h7c
    } alu_op_e;

    typedef struct packed {
        opcode_e   op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        func_e     func;
    } r_fmt_t;

    typedef struct packed {
        opcode_e    op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    // one instruction word, two field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_t;

endpackage

/* id_decode.sv */
module id_decode
    import mips_pkg::*;
(
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    input  inst_t     bus_inst_i,
    input  word_t     reg1_data_i,
    input  word_t     reg2_data_i,
    output logic      inst_ok_o,
    output reg_addr_t reg1_addr_o,
    output reg_addr_t reg2_addr_o,
    output logic      valid_o,
    output alu_sel_e  alusel_o,
    output alu_op_e   aluop_o,
    output word_t     opnd1_o,
    output word_t     opnd2_o,
    output reg_addr_t waddr_o,
    output logic      wreg_o
);

    logic  is_rform;
    logic  shift_reg;
    logic  shift_imm;
    logic  rd1_en;
    logic  rd2_en;
    word_t imm32;

    // register forms need shamt zero, immediate shifts need it nonzero
    function automatic logic check_inst(inst_t w);
        logic ok;
        ok = 1'b0;
        case (w.r.op)
            OP_SPECIAL: begin
                if (w.r.shamt == 5'd0) begin
                    ok = w.r.func inside {FN_SLL, FN_SLLV, FN_SRLV, FN_SRAV,
                                          FN_MOVZ, FN_MOVN, FN_SYNC,
                                          FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                                          FN_AND, FN_OR, FN_XOR, FN_NOR,
                                          FN_SLT, FN_SLTU};
                end else begin
                    ok = w.r.func inside {FN_SLL, FN_SRL, FN_SRA};
                end
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: ok = 1'b1;
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: ok = 1'b1;
            OP_PREF: ok = 1'b1;
            default: ok = 1'b0;
        endcase
        return ok;
    endfunction

    function automatic alu_op_e func_op(func_e f);
        case (f)
            FN_AND: return ALU_AND;
            FN_OR: return ALU_OR;
            FN_XOR: return ALU_XOR;
            FN_NOR: return ALU_NOR;
            FN_SLL, FN_SLLV: return ALU_SLL;
            FN_SRL, FN_SRLV: return ALU_SRL;
            FN_SRA, FN_SRAV: return ALU_SRA;
            FN_ADD: return ALU_ADD;
            FN_ADDU: return ALU_ADDU;
            FN_SUB: return ALU_SUB;
            FN_SUBU: return ALU_SUBU;
            FN_SLT: return ALU_SLT;
            FN_SLTU: return ALU_SLTU;
            FN_MOVN: return ALU_MOVN;
            FN_MOVZ: return ALU_MOVZ;
            default: return ALU_NOP;
        endcase
    endfunction

    assign inst_ok_o = check_inst(bus_inst_i);
    assign valid_o   = inst_valid_i;

    // shifts take the value from rt and the amount from rs or shamt
    assign is_rform  = (inst_i.r.op == OP_SPECIAL) && (inst_i.r.shamt == 5'd0);
    assign shift_reg = is_rform && (inst_i.r.func inside {FN_SLLV, FN_SRLV, FN_SRAV});
    assign shift_imm = (inst_i.r.op == OP_SPECIAL) && (inst_i.r.shamt != 5'd0);

    assign reg1_addr_o = (shift_reg || shift_imm) ? inst_i.r.rt : inst_i.r.rs;
    assign reg2_addr_o = shift_reg ? inst_i.r.rs : inst_i.r.rt;

    always_comb begin
        alusel_o = SEL_NOP;
        aluop_o  = ALU_NOP;
        waddr_o  = inst_i.i.rt;
        wreg_o   = 1'b0;
        rd1_en   = 1'b0;
        rd2_en   = 1'b0;
        imm32    = '0;

        case (inst_i.r.op)
            OP_SPECIAL: begin
                waddr_o = inst_i.r.rd;
                aluop_o = func_op(inst_i.r.func);
                if (inst_i.r.shamt == 5'd0) begin
                    rd1_en = 1'b1;
                    rd2_en = 1'b1;
                    wreg_o = 1'b1;
                    case (inst_i.r.func)
                        FN_AND, FN_OR, FN_XOR, FN_NOR: alusel_o = SEL_LOGIC;
                        FN_SLLV, FN_SRLV, FN_SRAV: alusel_o = SEL_SHIFT;
                        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU: alusel_o = SEL_ARITH;
                        FN_SLT, FN_SLTU: alusel_o = SEL_ARITH;
                        FN_MOVN: begin
                            alusel_o = SEL_MOVE;
                            // rt already carries the bypassed value
                            wreg_o   = (reg2_data_i != '0);
                        end
                        FN_MOVZ: begin
                            alusel_o = SEL_MOVE;
                            wreg_o   = (reg2_data_i == '0);
                        end
                        default: begin
                            // nop and sync
                            aluop_o = ALU_NOP;
                            rd1_en  = 1'b0;
                            rd2_en  = 1'b0;
                            wreg_o  = 1'b0;
                        end
                    endcase
                end else begin
                    alusel_o = SEL_SHIFT;
                    rd1_en   = 1'b1;
                    wreg_o   = 1'b1;
                    imm32    = word_t'(inst_i.r.shamt);
                end
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                alusel_o = SEL_LOGIC;
                rd1_en   = 1'b1;
                wreg_o   = 1'b1;
                imm32    = {16'h0000, inst_i.i.imm16};
                case (inst_i.i.op)
                    OP_ANDI: aluop_o = ALU_AND;
                    OP_ORI: aluop_o = ALU_OR;
                    default: aluop_o = ALU_XOR;
                endcase
            end
            OP_LUI: begin
                // rs is ignored, zero or'ed with the shifted immediate
                alusel_o = SEL_LOGIC;
                aluop_o  = ALU_OR;
                wreg_o   = 1'b1;
                imm32    = {inst_i.i.imm16, 16'h0000};
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                alusel_o = SEL_ARITH;
                rd1_en   = 1'b1;
                wreg_o   = 1'b1;
                imm32    = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
                case (inst_i.i.op)
                    OP_ADDI: aluop_o = ALU_ADD;
                    OP_ADDIU: aluop_o = ALU_ADDU;
                    OP_SLTI: aluop_o = ALU_SLT;
                    default: aluop_o = ALU_SLTU;
                endcase
            end
            default: begin
                // pref and anything else leave the state alone
                alusel_o = SEL_NOP;
            end
        endcase
    end

    assign opnd1_o = rd1_en ? reg1_data_i : '0;
    assign opnd2_o = rd2_en ? reg2_data_i : imm32;

endmodule

/* regfile.sv */
`include "mips_cfg.svh"

module regfile
    import mips_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    input  reg_addr_t host_addr_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    output word_t     host_data_o
);

    word_t     regs [`MIPS_REG_NUM];
    logic      wr_ok;
    reg_addr_t raddr [3];
    word_t     rdata [3];

    // r0 is never written
    assign wr_ok = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `MIPS_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign raddr[0] = raddr1_i;
    assign raddr[1] = raddr2_i;
    assign raddr[2] = host_addr_i;

    // same-cycle write is forwarded to every read port
    for (genvar p = 0; p < 3; p++) begin : g_rd
        always_comb begin
            if (wr_ok && (raddr[p] == waddr_i)) begin
                rdata[p] = wdata_i;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

    assign rdata1_o    = rdata[0];
    assign rdata2_o    = rdata[1];
    assign host_data_o = rdata[2];

endmodule

/* ex_stage.sv */
module ex_stage
    import mips_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      valid_i,
    input  alu_sel_e  alusel_i,
    input  alu_op_e   aluop_i,
    input  word_t     opnd1_i,
    input  word_t     opnd2_i,
    input  reg_addr_t waddr_i,
    input  logic      wreg_i,
    output logic      busy_o,
    output logic      wr_en_o,
    output reg_addr_t wr_addr_o,
    output word_t     wr_data_o
);

    logic       valid_q;
    logic       wreg_q;
    alu_sel_e   alusel_q;
    alu_op_e    aluop_q;
    word_t      opnd1_q;
    word_t      opnd2_q;
    reg_addr_t  waddr_q;
    logic [4:0] sa;
    word_t      sum;
    word_t      diff;
    word_t      logic_res;
    word_t      shift_res;
    word_t      arith_res;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            wreg_q  <= 1'b0;
        end else begin
            valid_q <= valid_i;
            wreg_q  <= valid_i && wreg_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            alusel_q <= alusel_i;
            aluop_q  <= aluop_i;
            opnd1_q  <= opnd1_i;
            opnd2_q  <= opnd2_i;
            waddr_q  <= waddr_i;
        end
    end

    // shift amount is the low five bits of operand 2
    assign sa   = opnd2_q[4:0];
    assign sum  = opnd1_q + opnd2_q;
    assign diff = opnd1_q - opnd2_q;

    always_comb begin
        case (aluop_q)
            ALU_OR: logic_res = opnd1_q | opnd2_q;
            ALU_XOR: logic_res = opnd1_q ^ opnd2_q;
            ALU_NOR: logic_res = ~(opnd1_q | opnd2_q);
            default: logic_res = opnd1_q & opnd2_q;
        endcase
    end

    always_comb begin
        case (aluop_q)
            ALU_SRL: shift_res = opnd1_q >> sa;
            ALU_SRA: shift_res = word_t'($signed(opnd1_q) >>> sa);
            default: shift_res = opnd1_q << sa;
        endcase
    end

    // add and sub wrap, no overflow trap
    always_comb begin
        case (aluop_q)
            ALU_SUB, ALU_SUBU: arith_res = diff;
            ALU_SLT: arith_res = word_t'($signed(opnd1_q) < $signed(opnd2_q));
            ALU_SLTU: arith_res = word_t'(opnd1_q < opnd2_q);
            default: arith_res = sum;
        endcase
    end

    always_comb begin
        case (alusel_q)
            SEL_LOGIC: wr_data_o = logic_res;
            SEL_SHIFT: wr_data_o = shift_res;
            SEL_ARITH: wr_data_o = arith_res;
            SEL_MOVE: wr_data_o = opnd1_q;
            default: wr_data_o = '0;
        endcase
    end

    assign busy_o    = valid_q;
    assign wr_en_o   = wreg_q;
    assign wr_addr_o = waddr_q;

endmodule

/* wb_front.sv */
`include "mips_cfg.svh"

module wb_front
    import mips_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [`MIPS_WB_AW-1:0] wb_adr_i,
    input  word_t                  wb_dat_i,
    output word_t                  wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   wb_err_o,
    input  logic                   inst_ok_i,
    input  logic                   ex_busy_i,
    input  word_t                  host_data_i,
    output logic                   inst_valid_o,
    output inst_t                  inst_o,
    output reg_addr_t              host_addr_o
);

    logic req;
    logic inst_wr;
    logic reg_rd;
    logic inst_take;
    logic rd_done;
    logic err_d;

    // no new request while the previous answer is still on the bus
    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;

    assign inst_wr = wb_we_i && (wb_adr_i == `MIPS_WB_INST_ADR);
    assign reg_rd  = !wb_we_i && wb_adr_i[`MIPS_WB_REG_SEL];

    assign inst_take = req && inst_wr && inst_ok_i;

    // reads wait until nothing is left in flight
    assign rd_done = req && reg_rd && !inst_valid_o && !ex_busy_i;

    assign err_d = req && !reg_rd && !(inst_wr && inst_ok_i);

    assign host_addr_o = wb_adr_i[2 +: `MIPS_REG_AW];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o     <= 1'b0;
            wb_err_o     <= 1'b0;
            inst_valid_o <= 1'b0;
        end else begin
            wb_ack_o     <= inst_take || rd_done;
            wb_err_o     <= err_d;
            inst_valid_o <= inst_take;
        end
    end

    always_ff @(posedge clk_i) begin
        if (inst_take) begin
            inst_o <= wb_dat_i;
        end
        if (rd_done) begin
            wb_dat_o <= host_data_i;
        end
    end

endmodule

/* mips_core.sv */
`include "mips_cfg.svh"

module mips_core
    import mips_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [`MIPS_WB_AW-1:0] wb_adr_i,
    input  word_t                  wb_dat_i,
    output word_t                  wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   wb_err_o
);

    logic      inst_ok;
    logic      ex_busy;
    logic      inst_valid;
    inst_t     inst;
    reg_addr_t host_addr;
    word_t     host_data;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    word_t     reg1_data;
    word_t     reg2_data;
    logic      dec_valid;
    alu_sel_e  dec_alusel;
    alu_op_e   dec_aluop;
    word_t     dec_opnd1;
    word_t     dec_opnd2;
    reg_addr_t dec_waddr;
    logic      dec_wreg;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    wb_front i_wb_front (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .wb_err_o     (wb_err_o),
        .inst_ok_i    (inst_ok),
        .ex_busy_i    (ex_busy),
        .host_data_i  (host_data),
        .inst_valid_o (inst_valid),
        .inst_o       (inst),
        .host_addr_o  (host_addr)
    );

    // bus word is judged here before it is captured
    id_decode i_id_decode (
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .bus_inst_i   (wb_dat_i),
        .reg1_data_i  (reg1_data),
        .reg2_data_i  (reg2_data),
        .inst_ok_o    (inst_ok),
        .reg1_addr_o  (reg1_addr),
        .reg2_addr_o  (reg2_addr),
        .valid_o      (dec_valid),
        .alusel_o     (dec_alusel),
        .aluop_o      (dec_aluop),
        .opnd1_o      (dec_opnd1),
        .opnd2_o      (dec_opnd2),
        .waddr_o      (dec_waddr),
        .wreg_o       (dec_wreg)
    );

    regfile i_regfile (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .we_i        (wr_en),
        .waddr_i     (wr_addr),
        .wdata_i     (wr_data),
        .raddr1_i    (reg1_addr),
        .raddr2_i    (reg2_addr),
        .host_addr_i (host_addr),
        .rdata1_o    (reg1_data),
        .rdata2_o    (reg2_data),
        .host_data_o (host_data)
    );

    ex_stage i_ex_stage (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .valid_i   (dec_valid),
        .alusel_i  (dec_alusel),
        .aluop_i   (dec_aluop),
        .opnd1_i   (dec_opnd1),
        .opnd2_i   (dec_opnd2),
        .waddr_i   (dec_waddr),
        .wreg_i    (dec_wreg),
        .busy_o    (ex_busy),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data)
    );

endmodule

/* tb_mips_core.sv */
`include "mips_cfg.svh"

module tb_mips_core
    import mips_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic                   clk_i;
    logic                   arst_n_i;
    logic                   wb_cyc_i;
    logic                   wb_stb_i;
    logic                   wb_we_i;
    logic [`MIPS_WB_AW-1:0] wb_adr_i;
    word_t                  wb_dat_i;
    word_t                  wb_dat_o;
    logic                   wb_ack_o;
    logic                   wb_err_o;

    word_t       ref_regs [32];
    logic [31:0] rng_state = 32'd67;
    int          n_checks  = 0;
    int          n_errors  = 0;
    logic        timed_out = 1'b0;

    mips_core i_dut (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .wb_err_o (wb_err_o)
    );

    always #10 clk_i = ~clk_i;

    function automatic word_t rand32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic word_t enc_r(input logic [5:0] op, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [4:0] rd,
                                    input logic [4:0] sa, input logic [5:0] fn);
        return {op, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // group 0 logic, 1 shift, 2 arith, 3 moves and nops
    function automatic word_t gen_inst(input int grp);
        word_t      r;
        word_t      w;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        int         k;
        r  = rand32();
        rs = {2'b00, r[2:0]};
        rt = {2'b00, r[5:3]};
        rd = {2'b00, r[8:6]};
        sa = (r[13:9] == 5'd0) ? 5'd31 : r[13:9];
        k  = int'(rand32() % 32'd60);
        case (grp)
            0: begin
                case (k % 8)
                    0: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h24);
                    1: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h25);
                    2: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h26);
                    3: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h27);
                    4: w = enc_i(6'h0c, rs, rt, r[31:16]);
                    5: w = enc_i(6'h0d, rs, rt, r[31:16]);
                    6: w = enc_i(6'h0e, rs, rt, r[31:16]);
                    default: w = enc_i(6'h0f, 5'd0, rt, r[31:16]);
                endcase
            end
            1: begin
                case (k % 6)
                    0: w = enc_r(6'h00, 5'd0, rt, rd, sa, 6'h00);
                    1: w = enc_r(6'h00, 5'd0, rt, rd, sa, 6'h02);
                    2: w = enc_r(6'h00, 5'd0, rt, rd, sa, 6'h03);
                    3: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h04);
                    4: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h06);
                    default: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h07);
                endcase
            end
            2: begin
                case (k % 10)
                    0: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h20);
                    1: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h21);
                    2: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h22);
                    3: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h23);
                    4: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h2a);
                    5: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h2b);
                    6: w = enc_i(6'h08, rs, rt, r[31:16]);
                    7: w = enc_i(6'h09, rs, rt, r[31:16]);
                    8: w = enc_i(6'h0a, rs, rt, r[31:16]);
                    default: w = enc_i(6'h0b, rs, rt, r[31:16]);
                endcase
            end
            default: begin
                case (k % 6)
                    0: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h0b);
                    1: w = enc_r(6'h00, rs, rt, rd, 5'd0, 6'h0a);
                    2: w = 32'h0000_0000;
                    3: w = 32'h0000_000f;
                    4: w = 32'h0000_0040;
                    default: w = enc_i(6'h33, rs, rt, r[31:16]);
                endcase
            end
        endcase
        return w;
    endfunction

    // reference behavior of one accepted instruction
    task automatic model_exec(input word_t w);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] sa;
        logic [4:0] dst;
        word_t      a;
        word_t      b;
        word_t      imm_s;
        word_t      imm_z;
        word_t      res;
        logic       wr;
        op    = w[31:26];
        fn    = w[5:0];
        sa    = w[10:6];
        a     = ref_regs[w[25:21]];
        b     = ref_regs[w[20:16]];
        imm_s = {{16{w[15]}}, w[15:0]};
        imm_z = {16'h0000, w[15:0]};
        dst   = (op == 6'h00) ? w[15:11] : w[20:16];
        wr    = 1'b1;
        res   = '0;
        case (op)
            6'h00: begin
                case (fn)
                    6'h00: res = b << sa;
                    6'h02: res = b >> sa;
                    6'h03: res = $signed(b) >>> sa;
                    6'h04: res = b << a[4:0];
                    6'h06: res = b >> a[4:0];
                    6'h07: res = $signed(b) >>> a[4:0];
                    6'h0a, 6'h0b: res = a;
                    6'h20, 6'h21: res = a + b;
                    6'h22, 6'h23: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h27: res = ~(a | b);
                    6'h2a: res = {31'd0, $signed(a) < $signed(b)};
                    6'h2b: res = {31'd0, a < b};
                    default: wr = 1'b0;
                endcase
                // sll by zero is the nop encoding
                if (fn == 6'h00 && sa == 5'd0) begin
                    wr = 1'b0;
                end
                if (fn == 6'h0a) begin
                    wr = (b == '0);
                end
                if (fn == 6'h0b) begin
                    wr = (b != '0);
                end
            end
            6'h08, 6'h09: res = a + imm_s;
            6'h0a: res = {31'd0, $signed(a) < $signed(imm_s)};
            6'h0b: res = {31'd0, a < imm_s};
            6'h0c: res = a & imm_z;
            6'h0d: res = a | imm_z;
            6'h0e: res = a ^ imm_z;
            6'h0f: res = {w[15:0], 16'h0000};
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) begin
            ref_regs[dst] = res;
        end
    endtask

    task automatic check(input word_t got, input word_t exp, input string what);
        n_checks++;
        if (!timed_out && got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [7:0] adr, input word_t wdat,
                             output logic ack, output logic err, output word_t rdat);
        int cnt;
        ack  = 1'b0;
        err  = 1'b0;
        rdat = '0;
        cnt  = 0;
        if (!timed_out) begin
            @(negedge clk_i);
            wb_cyc_i = 1'b1;
            wb_stb_i = 1'b1;
            wb_we_i  = we;
            wb_adr_i = adr;
            wb_dat_i = wdat;
            @(negedge clk_i);
            while (!wb_ack_o && !wb_err_o && cnt < WAIT_LIMIT) begin
                @(negedge clk_i);
                cnt++;
            end
            ack  = wb_ack_o;
            err  = wb_err_o;
            rdat = wb_dat_o;
            if (ack && err) begin
                n_errors++;
                $display("ack and err were both high at %0t, address %h", $time, adr);
            end
            if (!ack && !err) begin
                n_errors++;
                timed_out = 1'b1;
                $display("no ack or err within %0d cycles for address %h", WAIT_LIMIT, adr);
            end
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
            wb_we_i  = 1'b0;
        end
    endtask

    task automatic wb_write(input logic [7:0] adr, input word_t dat, output logic err);
        logic  ack;
        word_t unused;
        bus_cycle(1'b1, adr, dat, ack, err, unused);
    endtask

    task automatic wb_read(input logic [7:0] adr, output word_t dat, output logic err);
        logic ack;
        bus_cycle(1'b0, adr, '0, ack, err, dat);
    endtask

    task automatic issue(input word_t w);
        logic err;
        wb_write(`MIPS_WB_INST_ADR, w, err);
        check({31'd0, err}, 32'd0, $sformatf("err on instruction %h", w));
        model_exec(w);
    endtask

    task automatic read_check(input logic [4:0] n, input string what);
        word_t d;
        logic  err;
        wb_read({1'b1, n, 2'b00}, d, err);
        check({31'd0, err}, 32'd0, $sformatf("%s, err on read of r%0d", what, n));
        check(d, ref_regs[n], $sformatf("%s, r%0d", what, n));
    endtask

    task automatic sweep_regs(input string what);
        for (int i = 0; i < 32; i++) begin
            read_check(5'(i), what);
        end
    endtask

    task automatic run_group(input int grp, input int count, input string what);
        word_t w;
        for (int i = 0; i < count; i++) begin
            w = gen_inst(grp);
            issue(w);
            read_check(w[15:11], what);
            read_check(w[20:16], what);
        end
    endtask

    task automatic expect_err(input logic we, input logic [7:0] adr, input word_t dat,
                              input string what);
        logic  ack;
        logic  err;
        word_t d;
        bus_cycle(we, adr, dat, ack, err, d);
        check({31'd0, err}, 32'd1, $sformatf("%s, no err", what));
        check({31'd0, ack}, 32'd0, $sformatf("%s, unexpected ack", what));
    endtask

    initial begin
        clk_i    = 1'b0;
        arst_n_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        sweep_regs("after reset");
        run_group(0, 40, "logic");
        run_group(1, 40, "shift");

        // bursts of four with no reads in between
        for (int b = 0; b < 20; b++) begin
            for (int i = 0; i < 4; i++) begin
                issue(gen_inst(2));
            end
            for (int j = 0; j < 8; j++) begin
                read_check(5'(j), "arith burst");
            end
        end
        sweep_regs("arith sweep");

        // r0 stays zero, movz and movn with known rt
        issue(enc_i(6'h0d, 5'd0, 5'd1, 16'h1234));
        issue(enc_i(6'h0d, 5'd0, 5'd2, 16'h0000));
        issue(enc_i(6'h0d, 5'd1, 5'd0, 16'hffff));
        issue(enc_r(6'h00, 5'd1, 5'd1, 5'd0, 5'd0, 6'h21));
        issue(enc_r(6'h00, 5'd1, 5'd2, 5'd4, 5'd0, 6'h0a));
        issue(enc_r(6'h00, 5'd1, 5'd2, 5'd5, 5'd0, 6'h0b));
        issue(enc_r(6'h00, 5'd2, 5'd1, 5'd6, 5'd0, 6'h0b));
        sweep_regs("moves");
        run_group(3, 40, "moves and nops");
        sweep_regs("moves sweep");

        expect_err(1'b1, `MIPS_WB_INST_ADR, enc_r(6'h1c, 5'd1, 5'd2, 5'd3, 5'd0, 6'h02),
                   "special2 mul");
        expect_err(1'b1, `MIPS_WB_INST_ADR, enc_r(6'h1c, 5'd1, 5'd0, 5'd3, 5'd0, 6'h20),
                   "special2 clz");
        expect_err(1'b1, `MIPS_WB_INST_ADR, enc_i(6'h23, 5'd1, 5'd2, 16'h0010), "lw opcode");
        expect_err(1'b1, `MIPS_WB_INST_ADR, enc_i(6'h04, 5'd1, 5'd2, 16'h0004), "beq opcode");
        expect_err(1'b1, `MIPS_WB_INST_ADR, enc_r(6'h00, 5'd1, 5'd2, 5'd3, 5'd3, 6'h20),
                   "add with shamt");
        expect_err(1'b1, `MIPS_WB_INST_ADR, enc_r(6'h00, 5'd0, 5'd2, 5'd3, 5'd0, 6'h02),
                   "srl without shamt");
        expect_err(1'b1, `MIPS_WB_INST_ADR, enc_r(6'h00, 5'd0, 5'd0, 5'd3, 5'd0, 6'h10),
                   "mfhi");
        expect_err(1'b1, 8'h84, 32'hdead_beef, "register write");
        expect_err(1'b1, 8'h04, enc_i(6'h0d, 5'd0, 5'd1, 16'h5555), "write to wrong address");
        expect_err(1'b0, `MIPS_WB_INST_ADR, '0, "instruction read");
        sweep_regs("after rejected requests");

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
mips_pkg.sv
id_decode.sv
regfile.sv
ex_stage.sv
wb_front.sv
mips_core.sv
tb_mips_core.sv

/* Makefile */
TOP = tb_mips_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module mips_core -f compile.f
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f compile.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
